// File: build.f
+incdir+logic
logic/dtuSamplePkg.sv
logic/dtuFramePkg.sv
logic/dtuInterfaces.sv
logic/baselineSubtractor.sv
logic/gainSelector.sv
logic/sampleEncoder.sv
logic/wordBuffer.sv
logic/dtuCore.sv
verification/dtuCoreTb.sv

// File: verification/dtuCoreTb.sv
`timescale 1ns/1ps
`include "dtuParams_defines.svh"

module dtuCoreTb
	import dtuSamplePkg::*;
	import dtuFramePkg::*;
();

	logic clk;
	logic reset;
	logic calibrationBusy;
	logic testEnable;
	logic handshake;
	gainModeT gainSelMode;
	logic [`DTU_SAMPLE_BITS-1:0] dataGain10;
	logic [`DTU_SAMPLE_BITS-1:0] dataGain01;
	logic [`DTU_SAMPLE_BITS-1:0] saturationValue;
	logic [`DTU_BASELINE_BITS-1:0] baselineGain10;
	logic [`DTU_BASELINE_BITS-1:0] baselineGain01;
	logic [`DTU_WORD_BITS-1:0] testWord;
	logic [`DTU_WORD_BITS-1:0] dataOut;
	logic dataValid;
	logic losingData;

	logic [`DTU_WORD_BITS-1:0] expected[$];	// Completed words, oldest first
	logic [`DTU_SAMPLE_BITS:0] partFields[4];
	int partType;	// 0 empty, 1 baseline, 2 signal
	int partCount;
	int errors;
	int wordsMade;
	int wordsRead;
	int lossCount;
	logic readEnable;
	logic timedOut;

	dtuCore DUT (.*);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	task automatic checkEqual(input logic [31:0] got, input logic [31:0] want, input string what);
		if (got !== want) begin
			errors++;
			$display("** Error at %0t ns: %s, got %h, expected %h", $time, what, got, want);
		end
	endtask

	// Later waits are skipped once one has expired
	task automatic reportTimeout(input string why);
		errors++;
		timedOut = 1'b1;
		$display("Timeout: %s", why);
	endtask

	// Ship the partial word of the model
	function automatic void flushPartial();
		logic [`DTU_WORD_BITS-1:0] w;
		w = '0;
		w[29:27] = 3'(partCount);
		if (partType == 1) begin
			w[31:30] = WORD_BASELINE;
			for (int i = 0; i < partCount; i++)
				w[6*i +: 6] = partFields[i][5:0];	// Low six bits only
		end else begin
			w[31:30] = WORD_SIGNAL;
			for (int i = 0; i < partCount; i++)
				w[13*i +: 13] = partFields[i];
		end
		expected.push_back(w);
		wordsMade++;
		partType = 0;
		partCount = 0;
	endfunction

	function automatic void modelSample(input logic [11:0] d10, input logic [11:0] d01);
		int g10;
		int g01;
		int chosen;
		int kind;
		logic useLow;
		g10 = int'(d10) - int'(baselineGain10);
		g01 = int'(d01) - int'(baselineGain01);
		if (g10 < 0)
			g10 = 0;
		if (g01 < 0)
			g01 = 0;
		case (gainSelMode)
			GAIN_FORCE10: useLow = 1'b0;
			GAIN_FORCE01: useLow = 1'b1;
			default:      useLow = (d10 >= saturationValue);
		endcase
		chosen = useLow ? g01 : g10;
		kind = (!useLow && chosen < `DTU_BASELINE_LIMIT) ? 1 : 2;
		if (partType != 0 && partType != kind)
			flushPartial();	// Type change closes the old word
		partType = kind;
		partFields[partCount] = {useLow, 12'(chosen)};
		partCount++;
		if (partCount == ((kind == 1) ? 4 : 2))
			flushPartial();
	endfunction

	function automatic logic [11:0] mixedSample();
		if ($urandom_range(0, 1) == 1)
			return 12'($urandom_range(0, 300));	// Near baseline
		return 12'($urandom_range(0, 4095));
	endfunction

	// One clock: serve the reader, then drive the next sample
	task automatic step(input logic busy, input logic [11:0] d10, input logic [11:0] d01);
		@(posedge clk);
		#2;
		lossCount += losingData;
		if (testEnable) begin
			checkEqual(dataOut, testWord, "dataOut in test mode");
			checkEqual(dataValid, 1'b1, "dataValid in test mode");
			handshake = 1'b1;	// Must not pop anything
		end else if (readEnable && dataValid) begin
			if (expected.size() == 0) begin
				errors++;
				$display("Word %h was read while the model expected no word", dataOut);
			end else begin
				checkEqual(dataOut, expected.pop_front(), "popped word");
			end
			wordsRead++;
			handshake = 1'b1;
		end else begin
			handshake = 1'b0;
		end
		calibrationBusy = busy;
		dataGain10 = d10;
		dataGain01 = d01;
		if (!busy)
			modelSample(d10, d01);
	endtask

	task automatic idle(input int cycles);
		repeat (cycles) step(1'b1, '0, '0);
	endtask

	task automatic drain(input string phase);
		int waited;
		waited = 0;
		while (expected.size() != 0 && !timedOut) begin
			idle(1);
			waited++;
			if (waited == 400)
				reportTimeout({"expected words never came out during ", phase});
		end
	endtask

	initial begin
		int startWords;
		int waited;
		void'($urandom(29));
		{errors, wordsMade, wordsRead, lossCount, partType, partCount} = '0;
		timedOut = 1'b0;
		reset = 1'b1;
		calibrationBusy = 1'b1;	// Keeps intake off until stimulus starts
		testEnable = 1'b0;
		handshake = 1'b0;
		readEnable = 1'b0;
		gainSelMode = GAIN_AUTO;
		dataGain10 = '0;
		dataGain01 = '0;
		saturationValue = 12'hFFF;
		baselineGain10 = '0;
		baselineGain01 = '0;
		testWord = '0;
		repeat (10) @(posedge clk);
		#2 reset = 1'b0;

		baselineGain10 = 8'($urandom_range(0, 255));
		baselineGain01 = 8'($urandom_range(0, 255));
		saturationValue = 12'd3800;
		readEnable = 1'b1;
		repeat (300) step(1'b0, mixedSample(), 12'($urandom_range(0, 4095)));

		idle(4);	// Let the old mode finish its samples
		gainSelMode = GAIN_FORCE10;
		saturationValue = 12'd1000;	// Plenty of saturated samples
		repeat (150) step(1'b0, mixedSample(), 12'($urandom_range(0, 4095)));
		idle(4);
		gainSelMode = GAIN_FORCE01;
		repeat (150) step(1'b0, mixedSample(), 12'($urandom_range(0, 4095)));

		// Two small samples, then a large one
		idle(4);
		gainSelMode = GAIN_AUTO;
		baselineGain10 = 8'd10;
		saturationValue = 12'hFFF;
		for (int i = 0; i < 200; i++)
			step(1'b0, (i % 3 == 2) ? 12'($urandom_range(200, 4000)) : 12'($urandom_range(0, 70)),
				12'($urandom_range(0, 4095)));

		repeat (300) step($urandom_range(0, 3) == 0, mixedSample(), 12'($urandom_range(0, 4095)));
		drain("the calibration run");
		checkEqual(lossCount, 0, "losingData pulses while reading");

		// Serializer stalled, buffer overflows
		readEnable = 1'b0;
		startWords = wordsMade;
		repeat (120) step(1'b0, 12'($urandom_range(100, 4095)), 12'($urandom_range(0, 4095)));
		idle(8);	// Last load lands four edges after its sample
		while (expected.size() > `DTU_FIFO_DEPTH)
			void'(expected.pop_back());
		checkEqual(lossCount, wordsMade - startWords - `DTU_FIFO_DEPTH, "losingData pulses");
		readEnable = 1'b1;
		drain("the overflow read-back");

		readEnable = 1'b0;
		repeat (12) step(1'b0, 12'($urandom_range(100, 4095)), 12'($urandom_range(0, 4095)));
		waited = 0;
		while (!dataValid && !timedOut) begin
			idle(1);
			waited++;
			if (waited == 50)
				reportTimeout("no word reached the buffer before test mode");
		end
		testWord = $urandom();
		testEnable = 1'b1;
		idle(10);
		testEnable = 1'b0;
		handshake = 1'b0;
		readEnable = 1'b1;
		drain("the read-back after test mode");

		$display("Errors: %0d, words read: %0d, losingData pulses: %0d", errors, wordsRead,
			lossCount);
		if (errors == 0) begin
			$display("Result: PASSED");
		end else begin
			$display("Result: FAILED");
		end
		$finish;
	end

endmodule

// File: logic/dtuCore.sv
`timescale 1ns/1ps
`include "dtuParams_defines.svh"

module dtuCore
	import dtuSamplePkg::*;
(
	input  logic clk,
	input  logic reset,
	input  logic calibrationBusy,
	input  logic testEnable,
	input  gainModeT gainSelMode,
	input  logic [`DTU_SAMPLE_BITS-1:0] dataGain10,
	input  logic [`DTU_SAMPLE_BITS-1:0] dataGain01,
	input  logic [`DTU_SAMPLE_BITS-1:0] saturationValue,
	input  logic [`DTU_BASELINE_BITS-1:0] baselineGain10,
	input  logic [`DTU_BASELINE_BITS-1:0] baselineGain01,
	input  logic handshake,
	input  logic [`DTU_WORD_BITS-1:0] testWord,
	output logic [`DTU_WORD_BITS-1:0] dataOut,
	output logic dataValid,
	output logic losingData
);

	logic [`DTU_WORD_BITS-1:0] word;
	logic load;

	sampleLaneIf laneBus ();
	codedSampleIf codedBus ();

	baselineSubtractor subtractor (
		.clk(clk),
		.reset(reset),
		.calibrationBusy(calibrationBusy),
		.dataGain10(dataGain10),
		.dataGain01(dataGain01),
		.saturationValue(saturationValue),
		.baselineGain10(baselineGain10),
		.baselineGain01(baselineGain01),
		.lane(laneBus.source)
	);

	gainSelector selector (
		.clk(clk),
		.reset(reset),
		.gainSelMode(gainSelMode),
		.lane(laneBus.sink),
		.coded(codedBus.source)
	);

	sampleEncoder encoder (
		.clk(clk),
		.reset(reset),
		.coded(codedBus.sink),
		.word(word),
		.load(load)
	);

	wordBuffer buffer (
		.clk(clk),
		.reset(reset),
		.load(load),
		.handshake(handshake),
		.testEnable(testEnable),
		.word(word),
		.testWord(testWord),
		.dataOut(dataOut),
		.dataValid(dataValid),
		.losingData(losingData)
	);

endmodule

// File: logic/wordBuffer.sv
`timescale 1ns/1ps
`include "dtuParams_defines.svh"

module wordBuffer (
	input  logic clk,
	input  logic reset,
	input  logic load,
	input  logic handshake,
	input  logic testEnable,
	input  logic [`DTU_WORD_BITS-1:0] word,
	input  logic [`DTU_WORD_BITS-1:0] testWord,
	output logic [`DTU_WORD_BITS-1:0] dataOut,
	output logic dataValid,
	output logic losingData
);

	logic [`DTU_WORD_BITS-1:0] mem [`DTU_FIFO_DEPTH];
	logic [`DTU_FIFO_PTR_BITS-1:0] wrPtr;
	logic [`DTU_FIFO_PTR_BITS-1:0] rdPtr;
	logic [`DTU_FIFO_PTR_BITS:0] occupancy;	// One bit wider to reach full depth
	logic full;
	logic empty;
	logic write;
	logic pop;

	assign full = (occupancy == `DTU_FIFO_DEPTH);
	assign empty = (occupancy == '0);
	assign write = load && !full;
	assign pop = handshake && !testEnable && !empty;	// Serializer frozen in test mode

	always_ff @(posedge clk) begin
		if (reset) begin
			wrPtr <= '0;
			rdPtr <= '0;
			occupancy <= '0;
			losingData <= 1'b0;
		end else begin
			losingData <= load && full;
			if (write)
				wrPtr <= wrPtr + 1'b1;	// Wraps at depth
			if (pop)
				rdPtr <= rdPtr + 1'b1;
			case ({write, pop})
				2'b10:   occupancy <= occupancy + 1'b1;
				2'b01:   occupancy <= occupancy - 1'b1;
				default: occupancy <= occupancy;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (write)
			mem[wrPtr] <= word;
	end

	// Head word falls through
	assign dataOut = testEnable ? testWord : mem[rdPtr];
	assign dataValid = testEnable || !empty;

	occupancyBound: assert property (@(posedge clk) disable iff (reset)
		occupancy <= `DTU_FIFO_DEPTH)
		else $error("word buffer occupancy above depth");

	// Serializer strobes only while a word is offered
	noPopWhenEmpty: assert property (@(posedge clk) disable iff (reset)
		(handshake && !testEnable) |-> !empty)
		else $error("handshake on an empty word buffer");

endmodule

// File: logic/sampleEncoder.sv
`timescale 1ns/1ps
`include "dtuParams_defines.svh"

module sampleEncoder
	import dtuFramePkg::*;
(
	input  logic clk,
	input  logic reset,
	codedSampleIf.sink coded,
	output logic [`DTU_WORD_BITS-1:0] word,
	output logic load
);

	localparam int BASELINE_FIELD = 6;
	localparam int SIGNAL_FIELD = `DTU_SAMPLE_BITS + 1;	// Gain bit on top
	localparam int PAYLOAD_BITS = 2 * SIGNAL_FIELD;
	localparam logic [2:0] BASELINE_PER_WORD = 3'd4;
	localparam logic [2:0] SIGNAL_PER_WORD = 3'd2;

	encStateT state;
	encStateT sampleType;
	logic [2:0] count;
	logic [PAYLOAD_BITS-1:0] payload;
	logic flush;
	logic startFresh;
	logic [2:0] slot;
	logic [2:0] newCount;
	logic [PAYLOAD_BITS-1:0] newPayload;
	logic wordFull;

	function automatic logic [`DTU_WORD_BITS-1:0] packWord(
		input encStateT kind,
		input logic [2:0] n,
		input logic [PAYLOAD_BITS-1:0] p
	);
		if (kind == ENC_BASELINE)
			return {WORD_BASELINE, n, 3'b000, p[4*BASELINE_FIELD-1:0]};
		return {WORD_SIGNAL, n, 1'b0, p};
	endfunction

	always_comb begin
		sampleType = coded.isBaseline ? ENC_BASELINE : ENC_SIGNAL;
		flush = coded.valid && (state != ENC_EMPTY) && (state != sampleType);
		startFresh = (state == ENC_EMPTY) || flush;
		slot = startFresh ? 3'd0 : count;
		newCount = slot + 3'd1;
		newPayload = startFresh ? '0 : payload;
		if (coded.isBaseline) begin
			newPayload[slot*BASELINE_FIELD +: BASELINE_FIELD] =
				coded.sample[BASELINE_FIELD-1:0];
			wordFull = (newCount == BASELINE_PER_WORD);
		end else begin
			newPayload[slot*SIGNAL_FIELD +: SIGNAL_FIELD] = {coded.gainBit, coded.sample};
			wordFull = (newCount == SIGNAL_PER_WORD);
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= ENC_EMPTY;
			count <= '0;
			load <= 1'b0;
		end else begin
			load <= flush || (coded.valid && wordFull);
			if (coded.valid) begin
				if (wordFull) begin
					state <= ENC_EMPTY;
					count <= '0;
				end else begin
					state <= sampleType;
					count <= newCount;
				end
			end
		end
	end

	// Type change ships the old partial word, new sample opens the next one
	always_ff @(posedge clk) begin
		if (coded.valid) begin
			payload <= newPayload;
			if (flush)
				word <= packWord(state, count, payload);
			else if (wordFull)
				word <= packWord(sampleType, newCount, newPayload);
		end
	end

	// A shipped word holds one sample at least and no more than its type allows
	loadedWordCount: assert property (@(posedge clk) disable iff (reset)
		load |-> (word[29:27] != 3'd0) && (word[29:27] <=
			((word[31:30] == WORD_BASELINE) ? BASELINE_PER_WORD : SIGNAL_PER_WORD)))
		else $error("loaded word with an impossible sample count");

	countInRange: assert property (@(posedge clk) disable iff (reset)
		((state == ENC_BASELINE) |-> (count <= BASELINE_PER_WORD)) and
		((state == ENC_SIGNAL) |-> (count <= SIGNAL_PER_WORD)))
		else $error("partial word count beyond capacity");

endmodule

// File: logic/gainSelector.sv
`timescale 1ns/1ps
`include "dtuParams_defines.svh"

module gainSelector
	import dtuSamplePkg::*;
(
	input  logic clk,
	input  logic reset,
	input  gainModeT gainSelMode,
	sampleLaneIf.sink lane,
	codedSampleIf.source coded
);

	logic useGain01;
	logic [`DTU_SAMPLE_BITS-1:0] chosen;

	always_comb begin
		case (gainSelMode)
			GAIN_FORCE10: useGain01 = 1'b0;
			GAIN_FORCE01: useGain01 = 1'b1;
			default:      useGain01 = lane.saturated;	// Auto, also the spare code
		endcase
		chosen = useGain01 ? lane.gain01 : lane.gain10;
	end

	always_ff @(posedge clk) begin
		if (reset)
			coded.valid <= 1'b0;
		else
			coded.valid <= lane.valid;
	end

	// Only small x10 samples count as baseline
	always_ff @(posedge clk) begin
		coded.sample <= chosen;
		coded.gainBit <= useGain01;
		coded.isBaseline <= ~useGain01 && (chosen < `DTU_BASELINE_LIMIT);
	end

endmodule

// File: logic/baselineSubtractor.sv
`timescale 1ns/1ps
`include "dtuParams_defines.svh"

module baselineSubtractor (
	input  logic clk,
	input  logic reset,
	input  logic calibrationBusy,
	input  logic [`DTU_SAMPLE_BITS-1:0] dataGain10,
	input  logic [`DTU_SAMPLE_BITS-1:0] dataGain01,
	input  logic [`DTU_SAMPLE_BITS-1:0] saturationValue,
	input  logic [`DTU_BASELINE_BITS-1:0] baselineGain10,
	input  logic [`DTU_BASELINE_BITS-1:0] baselineGain01,
	sampleLaneIf.source lane
);

	// Subtract and floor at zero
	function automatic logic [`DTU_SAMPLE_BITS-1:0] clampSub(
		input logic [`DTU_SAMPLE_BITS-1:0] sample,
		input logic [`DTU_BASELINE_BITS-1:0] baseline
	);
		logic [`DTU_SAMPLE_BITS-1:0] wideBaseline;
		wideBaseline = {{(`DTU_SAMPLE_BITS - `DTU_BASELINE_BITS){1'b0}}, baseline};
		if (sample >= wideBaseline)
			return sample - wideBaseline;
		return '0;
	endfunction

	// Samples are simply skipped during calibration
	always_ff @(posedge clk) begin
		if (reset)
			lane.valid <= 1'b0;
		else
			lane.valid <= ~calibrationBusy;
	end

	always_ff @(posedge clk) begin
		lane.gain10 <= clampSub(dataGain10, baselineGain10);
		lane.gain01 <= clampSub(dataGain01, baselineGain01);
		lane.saturated <= (dataGain10 >= saturationValue);	// Raw value, before subtraction
	end

endmodule

// File: logic/dtuInterfaces.sv
`timescale 1ns/1ps
`include "dtuParams_defines.svh"

// Both gains after baseline subtraction
interface sampleLaneIf;
	logic [`DTU_SAMPLE_BITS-1:0] gain10;
	logic [`DTU_SAMPLE_BITS-1:0] gain01;
	logic saturated;	// Raw x10 at or above the saturation value
	logic valid;

	modport source (output gain10, gain01, saturated, valid);
	modport sink (input gain10, gain01, saturated, valid);
endinterface

// One chosen sample, classified for the encoder
interface codedSampleIf;
	logic [`DTU_SAMPLE_BITS-1:0] sample;
	logic gainBit;	// Set for x1
	logic isBaseline;
	logic valid;

	modport source (output sample, gainBit, isBaseline, valid);
	modport sink (input sample, gainBit, isBaseline, valid);
endinterface

// File: logic/dtuFramePkg.sv
package dtuFramePkg;

	// Header in bits 31..30 of every output word
	typedef enum logic [1:0] {
		WORD_BASELINE = 2'b01,	// Up to four 6-bit samples
		WORD_SIGNAL   = 2'b10	// Up to two 13-bit samples with gain bit
	} wordTypeT;

	// Kind of partial word held in the encoder
	typedef enum logic [1:0] {
		ENC_EMPTY,
		ENC_BASELINE,
		ENC_SIGNAL
	} encStateT;

endpackage

// File: logic/dtuSamplePkg.sv
package dtuSamplePkg;

	// Gain selection per sample
	//   GAIN_AUTO    x10 unless the x10 channel saturates
	//   GAIN_FORCE10 x10 always
	//   GAIN_FORCE01 x1 always
	// The remaining code 2'b11 is handled like GAIN_AUTO
	typedef enum logic [1:0] {
		GAIN_AUTO    = 2'b00,
		GAIN_FORCE10 = 2'b01,
		GAIN_FORCE01 = 2'b10
	} gainModeT;

endpackage

// File: logic/dtuParams_defines.svh
`ifndef DTU_PARAMS_DEFINES_SVH
`define DTU_PARAMS_DEFINES_SVH

// ADC sample width, both gains
`define DTU_SAMPLE_BITS 12

// Baseline register width
`define DTU_BASELINE_BITS 8

// Serializer word width
`define DTU_WORD_BITS 32

// Output buffer size
`define DTU_FIFO_DEPTH 16
`define DTU_FIFO_PTR_BITS 4

// Gain x10 samples under this value pack densely, so 6 bits are enough
`define DTU_BASELINE_LIMIT 64

`endif
